// ==== topic_value_buffer.f ====
+incdir+dv
hw/tvb_pkg.sv
hw/tvb_cmd_if.sv
hw/sync_ram_fifo.sv
hw/prefetch_fifo.sv
hw/buf_free_list.sv
hw/tvb_cmd_decode.sv
hw/tvb_value_store.sv
hw/tvb_result.sv
hw/topic_value_buffer.sv
dv/tb_topic_value_buffer.sv

// ==== dv/tb_tvb_tasks.svh ====
/*
 * Drive task, typed compare tasks, bounded waits and the directed tests
 * for the topic value buffer testbench.
 */
`ifndef TB_TVB_TASKS_SVH
`define TB_TVB_TASKS_SVH

// ****************************************************************************
// Compare tasks
// ****************************************************************************

task automatic compare_ptr(input buf_ptr_t got, input buf_ptr_t exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s pointer %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic compare_value(input value_t got, input value_t exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s data %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic compare_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s rsp_err %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic compare_op(input tvb_op_e got, input tvb_op_e exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s opcode %0d, expected %s", $time, what, got,
                 exp.name());
    end
endtask

// Status outputs such as init_done and free_empty.
task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// ****************************************************************************
// Drive and wait
// ****************************************************************************

// Called 1 ns after a rising edge, so the DUT samples the inputs cleanly.
task automatic drive_cmd(input logic valid, input tvb_op_e op, input buf_ptr_t ptr,
                         input value_t data);
    cmd_valid = valid;
    cmd_op    = op;
    cmd_ptr   = ptr;
    cmd_data  = data;
endtask

task automatic wait_init_done();
    int cycles;
    cycles = 0;
    while (!init_done && cycles < INIT_TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!init_done) begin
        failure_count++;
        $display("ERROR at %0t: init_done did not rise within %0d cycles", $time,
                 INIT_TIMEOUT);
    end
endtask

task automatic wait_free_nonempty();
    int cycles;
    cycles = 0;
    while (free_empty && cycles < FREE_TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (free_empty) begin
        failure_count++;
        $display("ERROR at %0t: freed buffers never reached the free list", $time);
    end
endtask

// Sends one command, waits for its response and checks every field.
// The pointer is only checked where the command defines it.
task automatic run_and_check(input tvb_op_e op, input buf_ptr_t ptr, input value_t data,
                             input tvb_op_e exp_op, input logic exp_err,
                             input value_t exp_data, input logic ptr_known,
                             input buf_ptr_t exp_ptr, input string what);
    int cycles;
    @(posedge clk);
    #1;
    drive_cmd(1'b1, op, ptr, data);
    @(posedge clk);
    #1;
    drive_cmd(1'b0, OP_NOP, '0, '0);
    // The edge that took the command counts as the first cycle.
    cycles = 1;
    while (!rsp_valid && cycles < RSP_TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!rsp_valid) begin
        failure_count++;
        $display("ERROR at %0t: no response to %s", $time, what);
    end else begin
        if (cycles != RSP_LATENCY) begin
            failure_count++;
            $display("ERROR at %0t: %s answered after %0d cycles instead of %0d",
                     $time, what, cycles, RSP_LATENCY);
        end
        compare_op(rsp_op, exp_op, what);
        compare_err(rsp_err, exp_err, what);
        compare_value(rsp_data, exp_data, what);
        if (ptr_known) begin
            compare_ptr(rsp_ptr, exp_ptr, what);
        end
    end
endtask

// ****************************************************************************
// Directed tests
// ****************************************************************************

task automatic check_reset_state();
    compare_flag(rsp_valid, 1'b0, "rsp_valid after reset");
    compare_flag(init_done, 1'b0, "init_done after reset");
    compare_flag(free_empty, 1'b1, "free_empty after reset");
endtask

// A fresh list hands out every pointer in ascending order, then runs dry.
task automatic test_alloc_all();
    wait_init_done();
    for (int i = 0; i < NUM_BUFS; i++) begin
        run_and_check(OP_ALLOC, '0, '1, OP_ALLOC, 1'b0, '0, 1'b1, buf_ptr_t'(i),
                      $sformatf("ALLOC %0d", i));
    end
    run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b1, '0, 1'b0, '0, "ALLOC on empty list");
endtask

task automatic test_write_read();
    buf_ptr_t ptrs [3];
    value_t   v;
    ptrs = '{4'd3, 4'd7, 4'd12};
    foreach (ptrs[i]) begin
        draw_value(v);
        stored_val[ptrs[i]] = v;
        run_and_check(OP_WRITE, ptrs[i], v, OP_WRITE, 1'b0, v, 1'b1, ptrs[i], "WRITE");
    end
    foreach (ptrs[i]) begin
        run_and_check(OP_READ, ptrs[i], '0, OP_READ, 1'b0, stored_val[ptrs[i]], 1'b1,
                      ptrs[i], "READ");
    end
endtask

// Released pointers come back in the order they were freed.
task automatic test_free_realloc();
    buf_ptr_t ptrs [3];
    ptrs = '{4'd9, 4'd2, 4'd14};
    foreach (ptrs[i]) begin
        run_and_check(OP_FREE, ptrs[i], 16'h1234, OP_FREE, 1'b0, '0, 1'b1, ptrs[i], "FREE");
    end
    wait_free_nonempty();
    foreach (ptrs[i]) begin
        run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b0, '0, 1'b1, ptrs[i],
                      "ALLOC of freed buffer");
    end
    run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b1, '0, 1'b0, '0, "ALLOC after refill");
endtask

task automatic test_init_restart();
    value_t v;
    run_and_check(OP_INIT, '0, '0, OP_INIT, 1'b0, '0, 1'b0, '0, "INIT");
    compare_flag(init_done, 1'b0, "init_done after INIT");
    // The list is still rebuilding, so both commands are refused.
    run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b1, '0, 1'b0, '0, "ALLOC during init");
    draw_value(v);
    run_and_check(OP_WRITE, 4'd3, v, OP_WRITE, 1'b1, '0, 1'b0, '0, "WRITE during init");
    wait_init_done();
    run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b0, '0, 1'b1, 4'd0, "first ALLOC after INIT");
    run_and_check(OP_ALLOC, '0, '0, OP_ALLOC, 1'b0, '0, 1'b1, 4'd1, "second ALLOC after INIT");
    // The refused WRITE must have left the old value in place.
    run_and_check(OP_READ, 4'd3, '0, OP_READ, 1'b0, stored_val[3], 1'b1, 4'd3,
                  "READ after refused WRITE");
endtask

task automatic test_back_to_back();
    tvb_op_e  op_list [4];
    buf_ptr_t ptr_list [4];
    value_t   data_list [4];
    buf_ptr_t exp_ptr [4];
    value_t   exp_data [4];
    value_t   v;
    int       j;
    run_and_check(tvb_op_e'(3'd6), 4'd5, 16'hbeef, OP_NOP, 1'b1, '0, 1'b0, '0,
                  "undefined opcode");
    draw_value(v);
    stored_val[1] = v;
    op_list   = '{OP_WRITE, OP_READ, OP_ALLOC, OP_ALLOC};
    ptr_list  = '{4'd1, 4'd1, 4'd0, 4'd0};
    data_list = '{v, 16'h0000, 16'h0000, 16'h0000};
    exp_ptr   = '{4'd1, 4'd1, 4'd2, 4'd3};
    exp_data  = '{v, v, 16'h0000, 16'h0000};
    @(posedge clk);
    #1;
    // One command per cycle. Command j answers at step j plus the latency.
    for (int s = 0; s < 7; s++) begin
        j = s - RSP_LATENCY;
        if (j >= 0) begin
            if (!rsp_valid) begin
                failure_count++;
                $display("ERROR at %0t: back-to-back command %0d got no response", $time, j);
            end else begin
                compare_op(rsp_op, op_list[j], "back-to-back");
                compare_ptr(rsp_ptr, exp_ptr[j], "back-to-back");
                compare_value(rsp_data, exp_data[j], "back-to-back");
                compare_err(rsp_err, 1'b0, "back-to-back");
            end
        end else if (rsp_valid) begin
            failure_count++;
            $display("ERROR at %0t: response arrived before any command was due", $time);
        end
        if (s < 4) begin
            drive_cmd(1'b1, op_list[s], ptr_list[s], data_list[s]);
        end else begin
            drive_cmd(1'b0, OP_NOP, '0, '0);
        end
        @(posedge clk);
        #1;
    end
endtask

`endif

// ==== dv/tb_topic_value_buffer.sv ====
/*
 * Testbench top for the topic value buffer manager.
 * Clock, reset, DUT instance, LFSR value source and the test sequence.
 */
`timescale 1ns/1ps

module tb_topic_value_buffer;
    import tvb_pkg::*;

    // Response latency in cycles and the bounds on every wait loop.
    localparam int RSP_LATENCY  = 3;
    localparam int RSP_TIMEOUT  = 10;
    localparam int INIT_TIMEOUT = 100;
    localparam int FREE_TIMEOUT = 50;

    logic     clk;
    logic     reset;
    logic     cmd_valid;
    tvb_op_e  cmd_op;
    buf_ptr_t cmd_ptr;
    value_t   cmd_data;
    logic     rsp_valid;
    tvb_op_e  rsp_op;
    buf_ptr_t rsp_ptr;
    value_t   rsp_data;
    logic     rsp_err;
    logic     init_done;
    logic     free_empty;

    int          mismatch_count;
    int          failure_count;
    logic [15:0] lfsr_state;
    // Last value written to each buffer, the reference for READ.
    value_t      stored_val [NUM_BUFS];

    topic_value_buffer u_topic_value_buffer (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_ptr   (cmd_ptr),
        .cmd_data  (cmd_data),
        .rsp_valid (rsp_valid),
        .rsp_op    (rsp_op),
        .rsp_ptr   (rsp_ptr),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err),
        .init_done (init_done),
        .free_empty(free_empty)
    );

    // 100 MHz clock.
    always begin
        #5 clk = ~clk;
    end

    // ************************************************************************
    // Value source
    // ************************************************************************

    // One step of a 16-bit Galois LFSR, taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hb400 : 16'h0000);
    endfunction

    // Each value bit is the bit shifted out of one LFSR step.
    task automatic draw_value(output value_t v);
        v = '0;
        for (int i = 0; i < VALUE_NBITS; i++) begin
            v          = {v[VALUE_NBITS-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    `include "tb_tvb_tasks.svh"

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = OP_NOP;
        cmd_ptr        = '0;
        cmd_data       = '0;
        mismatch_count = 0;
        failure_count  = 0;
        lfsr_state     = 16'd64;

        // Reset is held for ten cycles and released just after an edge.
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_state();
        test_alloc_all();
        test_write_read();
        test_free_realloc();
        test_init_restart();
        test_back_to_back();

        $display("Summary: %0d mismatches, %0d other failures", mismatch_count,
                 failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/topic_value_buffer.sv ====
/*
 * Topic value buffer manager top level.
 * Decode, execute and response stages around a shared free buffer list.
 */
`timescale 1ns/1ps

module topic_value_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  tvb_pkg::tvb_op_e  cmd_op,
    input  tvb_pkg::buf_ptr_t cmd_ptr,
    input  tvb_pkg::value_t   cmd_data,
    output logic              rsp_valid,
    output tvb_pkg::tvb_op_e  rsp_op,
    output tvb_pkg::buf_ptr_t rsp_ptr,
    output tvb_pkg::value_t   rsp_data,
    output logic              rsp_err,
    output logic              init_done,
    output logic              free_empty
);
    import tvb_pkg::*;

    // Execute to free list.
    logic     free_buf_rd;
    logic     rel_buf_valid;
    buf_ptr_t rel_buf_ptr;
    logic     freeb_init;
    buf_ptr_t free_buf_ptr;

    // Execute to response.
    logic     ex_valid;
    tvb_op_e  ex_op;
    buf_ptr_t ex_ptr;
    value_t   ex_data;
    logic     ex_err;

    tvb_cmd_if u_cmd_if ();

    tvb_cmd_decode u_tvb_cmd_decode (
        .clk      (clk),
        .reset    (reset),
        .cmd_valid(cmd_valid),
        .cmd_op   (cmd_op),
        .cmd_ptr  (cmd_ptr),
        .cmd_data (cmd_data),
        .cmd      (u_cmd_if.src)
    );

    tvb_value_store u_tvb_value_store (
        .clk          (clk),
        .reset        (reset),
        .cmd          (u_cmd_if.dst),
        .free_buf_ptr (free_buf_ptr),
        .freeb_empty  (free_empty),
        .init_done    (init_done),
        .free_buf_rd  (free_buf_rd),
        .rel_buf_valid(rel_buf_valid),
        .rel_buf_ptr  (rel_buf_ptr),
        .freeb_init   (freeb_init),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_ptr       (ex_ptr),
        .ex_data      (ex_data),
        .ex_err       (ex_err)
    );

    buf_free_list u_buf_free_list (
        .clk            (clk),
        .reset          (reset),
        .freeb_init     (freeb_init),
        .rel_buf_valid  (rel_buf_valid),
        .rel_buf_ptr    (rel_buf_ptr),
        .free_buf_rd    (free_buf_rd),
        .freeb_init_done(init_done),
        .freeb_empty    (free_empty),
        .free_buf_ptr   (free_buf_ptr)
    );

    tvb_result u_tvb_result (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_ptr   (ex_ptr),
        .ex_data  (ex_data),
        .ex_err   (ex_err),
        .rsp_valid(rsp_valid),
        .rsp_op   (rsp_op),
        .rsp_ptr  (rsp_ptr),
        .rsp_data (rsp_data),
        .rsp_err  (rsp_err)
    );

endmodule

// ==== hw/tvb_result.sv ====
/*
 * Response stage. Registers the response and clears the data field
 * where it carries no meaning.
 */
`timescale 1ns/1ps

module tvb_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_valid,
    input  tvb_pkg::tvb_op_e  ex_op,
    input  tvb_pkg::buf_ptr_t ex_ptr,
    input  tvb_pkg::value_t   ex_data,
    input  logic              ex_err,
    output logic              rsp_valid,
    output tvb_pkg::tvb_op_e  rsp_op,
    output tvb_pkg::buf_ptr_t rsp_ptr,
    output tvb_pkg::value_t   rsp_data,
    output logic              rsp_err
);
    import tvb_pkg::*;

    logic data_used;

    // Only a successful READ or WRITE returns a value.
    assign data_used = !ex_err && ((ex_op == OP_READ) || (ex_op == OP_WRITE));

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp_op   <= ex_op;
        rsp_ptr  <= ex_ptr;
        rsp_data <= data_used ? ex_data : '0;
        rsp_err  <= ex_err;
    end

endmodule

// ==== hw/tvb_value_store.sv ====
/*
 * Execute stage. Holds the value RAM and performs ALLOC, FREE, WRITE,
 * READ and INIT against the free list.
 */
`timescale 1ns/1ps

module tvb_value_store (
    input  logic              clk,
    input  logic              reset,
    tvb_cmd_if.dst            cmd,
    input  tvb_pkg::buf_ptr_t free_buf_ptr,
    input  logic              freeb_empty,
    input  logic              init_done,
    output logic              free_buf_rd,
    output logic              rel_buf_valid,
    output tvb_pkg::buf_ptr_t rel_buf_ptr,
    output logic              freeb_init,
    output logic              ex_valid,
    output tvb_pkg::tvb_op_e  ex_op,
    output tvb_pkg::buf_ptr_t ex_ptr,
    output tvb_pkg::value_t   ex_data,
    output logic              ex_err
);
    import tvb_pkg::*;

    value_t mem [NUM_BUFS];
    logic   cmd_err;

    // An ALLOC pops the prefetch head in the same cycle it is seen.
    assign free_buf_rd   = cmd.valid && (cmd.op == OP_ALLOC) && init_done && !freeb_empty;
    assign rel_buf_valid = cmd.valid && (cmd.op == OP_FREE) && init_done;
    assign rel_buf_ptr   = cmd.ptr;
    assign freeb_init    = cmd.valid && (cmd.op == OP_INIT);

    // INIT is always accepted. NOP never does anything, so it reports an error.
    // Any other command is refused until the free list is rebuilt.
    always_comb begin
        if (cmd.op == OP_INIT) begin
            cmd_err = 1'b0;
        end else if (cmd.op == OP_NOP || !init_done) begin
            cmd_err = 1'b1;
        end else if (cmd.op == OP_ALLOC) begin
            cmd_err = freeb_empty;
        end else begin
            cmd_err = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= cmd.valid;
        end
    end

    // The RAM read is registered here, alongside the rest of the result.
    always_ff @(posedge clk) begin
        if (cmd.valid && (cmd.op == OP_WRITE) && init_done) begin
            mem[cmd.ptr] <= cmd.data;
        end
        ex_op   <= cmd.op;
        ex_ptr  <= (cmd.op == OP_ALLOC) ? free_buf_ptr : cmd.ptr;
        ex_data <= (cmd.op == OP_READ) ? mem[cmd.ptr] : cmd.data;
        ex_err  <= cmd_err;
    end

endmodule

// ==== hw/tvb_cmd_decode.sv ====
/*
 * Command decode stage. Registers the client command and maps undefined
 * opcodes to OP_NOP.
 */
`timescale 1ns/1ps

module tvb_cmd_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  tvb_pkg::tvb_op_e  cmd_op,
    input  tvb_pkg::buf_ptr_t cmd_ptr,
    input  tvb_pkg::value_t   cmd_data,
    tvb_cmd_if.src            cmd
);
    import tvb_pkg::*;

    tvb_op_e dec_op;

    // Only the defined opcodes pass through unchanged.
    always_comb begin
        case (cmd_op)
            OP_INIT, OP_ALLOC, OP_FREE, OP_WRITE, OP_READ: dec_op = cmd_op;
            default: dec_op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= cmd_valid;
        end
    end

    // Opcode, pointer and data are payload, qualified by cmd.valid.
    always_ff @(posedge clk) begin
        cmd.op   <= dec_op;
        cmd.ptr  <= cmd_ptr;
        cmd.data <= cmd_data;
    end

endmodule

// ==== hw/buf_free_list.sv ====
/*
 * Free buffer pointer list. An init FSM fills a RAM FIFO with every pointer,
 * released pointers are written back a cycle later, and a prefetch FIFO
 * keeps the next free pointer ready.
 */
`timescale 1ns/1ps

module buf_free_list (
    input  logic             clk,
    input  logic             reset,
    input  logic             freeb_init,
    input  logic             rel_buf_valid,
    input  tvb_pkg::buf_ptr_t rel_buf_ptr,
    input  logic             free_buf_rd,
    output logic             freeb_init_done,
    output logic             freeb_empty,
    output tvb_pkg::buf_ptr_t free_buf_ptr
);
    import tvb_pkg::*;

    init_state_e init_st;
    init_state_e nxt_init_st;

    logic     fifo_reset;
    logic     freeb_init_wr;
    logic     rel_buf_valid_d1;
    buf_ptr_t rel_buf_ptr_d1;

    logic     fifo_wr;
    logic     fifo_rd;
    logic     fifo_rd_d1;
    logic     fifo_empty;
    buf_ptr_t fifo_din;
    buf_ptr_t fifo_dout;
    buf_ptr_t fifo_wptr;

    logic     prefetch_wr;
    logic     prefetch_rd;
    logic     prefetch_full;
    logic     prefetch_fullm1;
    logic     prefetch_empty;
    buf_ptr_t prefetch_dout;

    // ************************************************************************
    // Init FSM
    // ************************************************************************

    // The list is rebuilt after reset and on every client INIT.
    always_comb begin
        nxt_init_st = init_st;
        case (init_st)
            INIT_IDLE:   nxt_init_st = RESET_FREEB;
            RESET_FREEB: nxt_init_st = INIT_FREEB;
            // The last pointer is written as the write pointer wraps.
            INIT_FREEB:  if (&fifo_wptr) nxt_init_st = INIT_DONE;
            INIT_DONE:   if (freeb_init) nxt_init_st = INIT_IDLE;
            default:     nxt_init_st = INIT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            init_st          <= INIT_IDLE;
            fifo_reset       <= 1'b1;
            freeb_init_wr    <= 1'b0;
            rel_buf_valid_d1 <= 1'b0;
            fifo_rd_d1       <= 1'b0;
            freeb_init_done  <= 1'b0;
        end else begin
            init_st          <= nxt_init_st;
            fifo_reset       <= (nxt_init_st == RESET_FREEB);
            freeb_init_wr    <= (nxt_init_st == INIT_FREEB);
            rel_buf_valid_d1 <= rel_buf_valid;
            fifo_rd_d1       <= fifo_rd;
            // Done waits for the first pointer to land in the prefetch FIFO,
            // then holds until the next INIT.
            freeb_init_done  <= (nxt_init_st == INIT_DONE) &&
                                (freeb_init_done || !prefetch_empty);
        end
    end

    // Release pointer is only a payload, qualified by rel_buf_valid_d1.
    always_ff @(posedge clk) begin
        rel_buf_ptr_d1 <= rel_buf_ptr;
    end

    // ************************************************************************
    // RAM FIFO and prefetch
    // ************************************************************************

    // During init the FIFO stores its own write pointer, giving 0 to 15.
    assign fifo_wr  = freeb_init_wr | rel_buf_valid_d1;
    assign fifo_din = freeb_init_wr ? fifo_wptr : rel_buf_ptr_d1;

    // Drain into the prefetch FIFO only when the word has somewhere to go.
    // A read issued now lands two edges later, behind any pending write.
    // No read starts while the FIFOs are held in reset, so no stale pointer
    // reaches the prefetch FIFO after it has been cleared.
    assign fifo_rd = ~fifo_reset & ~freeb_init_wr & ~fifo_empty &
                     ~((prefetch_wr & prefetch_fullm1) | prefetch_full);

    assign prefetch_wr = fifo_rd_d1;
    assign prefetch_rd = freeb_init_done & free_buf_rd;

    assign free_buf_ptr = prefetch_dout;
    assign freeb_empty  = prefetch_empty;

    sync_ram_fifo #(
        .DATA_NBITS(BPTR_NBITS),
        .ADDR_NBITS(BPTR_NBITS)
    ) u_sync_ram_fifo (
        .clk       (clk),
        .fifo_reset(fifo_reset),
        .din       (fifo_din),
        .wr        (fifo_wr),
        .rd        (fifo_rd),
        .dout      (fifo_dout),
        .wptr      (fifo_wptr),
        .count     (),
        .full      (),
        .empty     (fifo_empty)
    );

    prefetch_fifo #(
        .DATA_NBITS(BPTR_NBITS),
        .DEPTH     (PREFETCH_DEPTH)
    ) u_prefetch_fifo (
        .clk       (clk),
        .fifo_reset(fifo_reset),
        .din       (fifo_dout),
        .wr        (prefetch_wr),
        .rd        (prefetch_rd),
        .dout      (prefetch_dout),
        .full      (prefetch_full),
        .fullm1    (prefetch_fullm1),
        .empty     (prefetch_empty)
    );

endmodule

// ==== hw/prefetch_fifo.sv ====
/*
 * Small flop FIFO with a show-ahead head word and a full-minus-one flag.
 */
`timescale 1ns/1ps

module prefetch_fifo #(
    parameter int DATA_NBITS = tvb_pkg::BPTR_NBITS,
    parameter int DEPTH      = tvb_pkg::PREFETCH_DEPTH
) (
    input  logic                  clk,
    input  logic                  fifo_reset,
    input  logic [DATA_NBITS-1:0] din,
    input  logic                  wr,
    input  logic                  rd,
    output logic [DATA_NBITS-1:0] dout,
    output logic                  full,
    output logic                  fullm1,
    output logic                  empty
);

    logic [DATA_NBITS-1:0]      mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wptr;
    logic [$clog2(DEPTH)-1:0]   rptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       wr_en;
    logic                       rd_en;

    assign wr_en = wr & ~full;
    assign rd_en = rd & ~empty;

    // The head entry is always on dout, so a pop needs no read latency.
    assign dout   = mem[rptr];
    assign full   = (count == DEPTH);
    assign fullm1 = (count == DEPTH - 1);
    assign empty  = (count == 0);

    always_ff @(posedge clk) begin
        if (fifo_reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= (wptr == DEPTH - 1) ? '0 : wptr + 1'b1;
            end
            if (rd_en) begin
                rptr <= (rptr == DEPTH - 1) ? '0 : rptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr] <= din;
        end
    end

endmodule

// ==== hw/sync_ram_fifo.sv ====
/*
 * Synchronous RAM FIFO with a registered read port.
 * The write pointer and the occupancy are visible to the caller.
 */
`timescale 1ns/1ps

module sync_ram_fifo #(
    parameter int DATA_NBITS = tvb_pkg::BPTR_NBITS,
    parameter int ADDR_NBITS = tvb_pkg::BPTR_NBITS
) (
    input  logic                  clk,
    input  logic                  fifo_reset,
    input  logic [DATA_NBITS-1:0] din,
    input  logic                  wr,
    input  logic                  rd,
    output logic [DATA_NBITS-1:0] dout,
    output logic [ADDR_NBITS-1:0] wptr,
    output logic [ADDR_NBITS:0]   count,
    output logic                  full,
    output logic                  empty
);

    logic [DATA_NBITS-1:0] mem [2**ADDR_NBITS];
    logic [ADDR_NBITS-1:0] rptr;
    logic                  wr_en;
    logic                  rd_en;

    // A write to a full FIFO or a read from an empty one is ignored.
    assign wr_en = wr & ~full;
    assign rd_en = rd & ~empty;

    // The count is one bit wider than the address, so its top bit is full.
    assign full  = count[ADDR_NBITS];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (fifo_reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1;
            end
            if (rd_en) begin
                rptr <= rptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and read data register. The word appears one cycle after rd.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wptr] <= din;
        end
        if (rd_en) begin
            dout <= mem[rptr];
        end
    end

endmodule

// ==== hw/tvb_cmd_if.sv ====
/*
 * Decoded command bundle passed from the decode stage to the execute stage.
 */
`timescale 1ns/1ps

interface tvb_cmd_if;
    import tvb_pkg::*;

    // One decoded command per cycle, qualified by valid.
    logic     valid;
    tvb_op_e  op;
    buf_ptr_t ptr;
    value_t   data;

    // Decode drives the bundle.
    modport src (output valid, op, ptr, data);
    // Execute consumes it.
    modport dst (input valid, op, ptr, data);

endinterface

// ==== hw/tvb_pkg.sv ====
/*
 * Shared widths, pool size and prefetch depth for the topic value buffer.
 * Buffer pointer and value types, the command opcode enum and the
 * free-list init state enum.
 */
package tvb_pkg;

    // Pool geometry. A pointer addresses one of NUM_BUFS value buffers.
    localparam int BPTR_NBITS     = 4;
    localparam int NUM_BUFS       = 16;
    localparam int VALUE_NBITS    = 16;
    // Depth of the show-ahead FIFO in front of the free list.
    localparam int PREFETCH_DEPTH = 2;

    typedef logic [BPTR_NBITS-1:0]  buf_ptr_t;
    typedef logic [VALUE_NBITS-1:0] value_t;

    // Client opcodes. Codes 6 and 7 are undefined and decode to OP_NOP.
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_INIT  = 3'd1,
        OP_ALLOC = 3'd2,
        OP_FREE  = 3'd3,
        OP_WRITE = 3'd4,
        OP_READ  = 3'd5
    } tvb_op_e;

    // Free-list initialisation FSM.
    typedef enum logic [1:0] {
        INIT_IDLE   = 2'd0,
        RESET_FREEB = 2'd1,
        INIT_FREEB  = 2'd2,
        INIT_DONE   = 2'd3
    } init_state_e;

endpackage
